//--- zcash_diff_pkg.sv
// ================================================
// SHA256d difficulty check shared definitions
// ================================================

package zcash_diff_pkg;

  // Default beat width in bytes
  localparam int DAT_BYTS_DEF   = 8;
  // Zcash header without the equihash solution
  localparam int HDR_BYTS_DEF   = 140;
  // Input buffer depth in beats, also the credit count
  localparam int FIFO_DEPTH_DEF = 16;

  // SHA-256 digest size
  localparam int DIGEST_BYTS    = 32;

  // Round constants, index 0 is the first round
  localparam logic [0:63][31:0] SHA_K = {
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial hash value, index 0 is H0
  localparam logic [0:7][31:0] SHA_H0 = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  // Block builder phases
  typedef enum logic [1:0] {
    FILL,        // Packing header beats
    PAD,         // Forming padding and length blocks
    WAIT_FIRST,  // First digest pending
    SECOND       // Digest block sent, second digest pending
  } build_state_e;

endpackage

//--- hdr_credit_fifo.sv
// ================================================
// Header beat FIFO with credit return
// ================================================
`timescale 1ns/10ps

module hdr_credit_fifo #(
  parameter int DAT_BYTS   = zcash_diff_pkg::DAT_BYTS_DEF,
  parameter int FIFO_DEPTH = zcash_diff_pkg::FIFO_DEPTH_DEF
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_val,
  input  logic [DAT_BYTS*8-1:0] i_dat,
  input  logic                  i_sop,
  input  logic                  i_eop,
  input  logic [31:0]           i_difficulty,
  input  logic                  i_pop,
  output logic                  o_val,
  output logic [DAT_BYTS*8-1:0] o_dat,
  output logic                  o_sop,
  output logic                  o_eop,
  output logic [31:0]           o_difficulty,
  output logic                  o_hdr_start,
  output logic                  o_credit
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [DAT_BYTS*8-1:0] dat_mem [FIFO_DEPTH];
  logic [31:0]           diff_mem [FIFO_DEPTH];
  logic                  sop_mem [FIFO_DEPTH];
  logic                  eop_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  pop;

  // Builder only pops a valid beat, the guard keeps count sane anyway
  assign pop = i_pop && o_val;

  assign o_val        = (count != '0);
  assign o_dat        = dat_mem[rd_ptr];
  assign o_sop        = sop_mem[rd_ptr];
  assign o_eop        = eop_mem[rd_ptr];
  assign o_difficulty = diff_mem[rd_ptr];
  // One credit back per beat leaving
  assign o_credit     = pop;
  assign o_hdr_start  = pop && o_sop;

  // Storage, no overflow check since the sender is credit limited
  always_ff @(posedge i_clk) begin
    if (i_val) begin
      dat_mem[wr_ptr] <= i_dat;
      sop_mem[wr_ptr] <= i_sop;
      eop_mem[wr_ptr] <= i_eop;
      // Difficulty only matters on the first beat of a header
      if (i_sop)
        diff_mem[wr_ptr] <= i_difficulty;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_val)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Push and pop together leave the count alone
      if (i_val && !pop)
        count <= count + 1'b1;
      else if (!i_val && pop)
        count <= count - 1'b1;
    end
  end

endmodule

//--- sha256_block_builder.sv
// ================================================
// SHA-256 block builder for SHA256d
// ================================================
`timescale 1ns/10ps

module sha256_block_builder #(
  parameter int DAT_BYTS = zcash_diff_pkg::DAT_BYTS_DEF,
  parameter int HDR_BYTS = zcash_diff_pkg::HDR_BYTS_DEF
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_fifo_val,
  input  logic [DAT_BYTS*8-1:0] i_fifo_dat,
  input  logic                  i_fifo_eop,
  input  logic                  i_blk_rdy,
  input  logic                  i_hash_val,
  input  logic [255:0]          i_hash_dat,
  output logic                  o_fifo_pop,
  output logic                  o_blk_val,
  output logic [511:0]          o_blk_dat,
  output logic                  o_blk_first,
  output logic                  o_blk_last,
  output logic                  o_hash_second
);

  import zcash_diff_pkg::*;

  // Message length field for each pass
  localparam logic [63:0] MSG_BITS = 64'(HDR_BYTS * 8);
  localparam logic [63:0] DIG_BITS = 64'(DIGEST_BYTS * 8);

  build_state_e state;
  // Byte 0 of the block sits in the top byte
  logic [511:0] blk_buf;
  logic [511:0] pad_blk;
  logic [5:0]   byt_cnt;
  logic [6:0]   nxt_cnt;
  logic         len_pend;
  logic         len_fits;
  logic         first_pend;

  assign o_blk_dat     = blk_buf;
  assign o_hash_second = (state == SECOND);

  // No popping while a block waits for the core
  assign o_fifo_pop = (state == FILL) && i_fifo_val && !o_blk_val;
  assign nxt_cnt    = {1'b0, byt_cnt} + 7'(DAT_BYTS);

  // Length goes in this block if 8 bytes are left after the 0x80
  assign len_fits = len_pend || (byt_cnt <= 6'd55);

  // Padding block from the partial data already in the buffer
  always_comb begin
    pad_blk = '0;
    for (int k = 0; k < 64; k++) begin
      if (k < byt_cnt)
        pad_blk[511-8*k -: 8] = blk_buf[511-8*k -: 8];
      else if (k == byt_cnt && !len_pend)
        pad_blk[511-8*k -: 8] = 8'h80;
    end
    if (len_fits)
      pad_blk[63:0] = MSG_BITS;
  end

  // Block data, written only while no block is pending
  always_ff @(posedge i_clk) begin
    if (o_fifo_pop) begin
      // Earliest beat byte lands at the lowest block byte
      for (int j = 0; j < DAT_BYTS; j++)
        blk_buf[511 - 8*(byt_cnt + j) -: 8] <= i_fifo_dat[8*j +: 8];
    end else if (state == PAD && !o_blk_val) begin
      blk_buf <= pad_blk;
    end else if (state == WAIT_FIRST && i_hash_val) begin
      // Digest, 0x80, zeros, then 256 bit length
      blk_buf <= {i_hash_dat, 8'h80, {((55 - DIGEST_BYTS) * 8){1'b0}}, DIG_BITS};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= FILL;
      byt_cnt     <= '0;
      len_pend    <= 1'b0;
      first_pend  <= 1'b1;
      o_blk_val   <= 1'b0;
      o_blk_first <= 1'b0;
      o_blk_last  <= 1'b0;
    end else begin
      if (o_blk_val && i_blk_rdy)
        o_blk_val <= 1'b0;

      case (state)
        FILL: begin
          if (o_fifo_pop) begin
            byt_cnt <= nxt_cnt[5:0];
            // 64th byte in, present the block
            if (nxt_cnt[6]) begin
              o_blk_val   <= 1'b1;
              o_blk_first <= first_pend;
              o_blk_last  <= 1'b0;
              first_pend  <= 1'b0;
            end
            if (i_fifo_eop)
              state <= PAD;
          end
        end
        PAD: begin
          if (!o_blk_val) begin
            o_blk_val   <= 1'b1;
            o_blk_first <= first_pend;
            first_pend  <= 1'b0;
            byt_cnt     <= '0;
            if (len_fits) begin
              o_blk_last <= 1'b1;
              len_pend   <= 1'b0;
              state      <= WAIT_FIRST;
            end else begin
              // Extra block carries only the length
              o_blk_last <= 1'b0;
              len_pend   <= 1'b1;
            end
          end
        end
        WAIT_FIRST: begin
          if (i_hash_val) begin
            o_blk_val   <= 1'b1;
            o_blk_first <= 1'b1;
            o_blk_last  <= 1'b1;
            state       <= SECOND;
          end
        end
        SECOND: begin
          // Second digest goes to the checker, next header may start
          if (i_hash_val) begin
            first_pend <= 1'b1;
            state      <= FILL;
          end
        end
        default: state <= FILL;
      endcase
    end
  end

endmodule

//--- sha256_compress.sv
// ================================================
// Iterative SHA-256 compression core
// ================================================
`timescale 1ns/10ps

module sha256_compress (
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_blk_val,
  input  logic [511:0] i_blk_dat,
  input  logic         i_blk_first,
  input  logic         i_blk_last,
  output logic         o_blk_rdy,
  output logic         o_hash_val,
  output logic [255:0] o_hash_dat
);

  import zcash_diff_pkg::*;

  // Rolling schedule, w[0] is W of the current round
  logic [31:0] w [16];
  // Working variables a..h
  logic [31:0] v [8];
  // Chaining value H0..H7
  logic [31:0] chain [8];
  logic        busy;
  logic        last_q;
  logic [6:0]  rnd;
  logic        accept;
  logic [31:0] t1;
  logic [31:0] t2;
  logic [31:0] w_nxt;

  function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic logic [31:0] bsig0(input logic [31:0] x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic logic [31:0] bsig1(input logic [31:0] x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic logic [31:0] ssig0(input logic [31:0] x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic logic [31:0] ssig1(input logic [31:0] x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  assign o_blk_rdy = !busy;
  assign accept    = i_blk_val && o_blk_rdy;

  // Big-endian digest, H0 in the top word
  assign o_hash_dat = {chain[0], chain[1], chain[2], chain[3],
                       chain[4], chain[5], chain[6], chain[7]};

  // Round logic, Ch and Maj folded in
  assign t1 = v[7] + bsig1(v[4]) + ((v[4] & v[5]) ^ (~v[4] & v[6]))
            + SHA_K[rnd[5:0]] + w[0];
  assign t2 = bsig0(v[0]) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
  // W for round t+16
  assign w_nxt = ssig1(w[14]) + w[9] + ssig0(w[1]) + w[0];

  always_ff @(posedge i_clk) begin
    if (accept) begin
      for (int i = 0; i < 16; i++)
        w[i] <= i_blk_dat[511-32*i -: 32];
      // First block of a message restarts from the IV
      for (int i = 0; i < 8; i++) begin
        if (i_blk_first) begin
          v[i]     <= SHA_H0[i];
          chain[i] <= SHA_H0[i];
        end else begin
          v[i] <= chain[i];
        end
      end
    end else if (busy && !rnd[6]) begin
      for (int i = 0; i < 15; i++)
        w[i] <= w[i+1];
      w[15] <= w_nxt;
      v[0] <= t1 + t2;
      v[1] <= v[0];
      v[2] <= v[1];
      v[3] <= v[2];
      v[4] <= v[3] + t1;
      v[5] <= v[4];
      v[6] <= v[5];
      v[7] <= v[6];
    end else if (busy) begin
      // Add cycle after round 63
      for (int i = 0; i < 8; i++)
        chain[i] <= chain[i] + v[i];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy       <= 1'b0;
      last_q     <= 1'b0;
      rnd        <= '0;
      o_hash_val <= 1'b0;
    end else begin
      o_hash_val <= 1'b0;
      if (accept) begin
        busy   <= 1'b1;
        last_q <= i_blk_last;
        rnd    <= '0;
      end else if (busy) begin
        if (rnd[6]) begin
          // Ready again and digest out together
          busy       <= 1'b0;
          o_hash_val <= last_q;
        end else begin
          rnd <= rnd + 1'b1;
        end
      end
    end
  end

endmodule

//--- difficulty_check.sv
// ================================================
// Digest difficulty checker
// ================================================
`timescale 1ns/10ps

module difficulty_check (
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_hdr_start,
  input  logic [31:0]  i_difficulty,
  input  logic         i_hash_val,
  input  logic         i_hash_second,
  input  logic [255:0] i_hash_dat,
  output logic         o_val,
  output logic         o_difficulty_fail
);

  import zcash_diff_pkg::*;

  logic [31:0] diff_act;
  logic [31:0] hold_diff;
  logic        act_busy;
  logic        hold_val;
  logic        verdict;
  logic [5:0]  lim;
  logic        fail_c;

  // Only the second pass digest is judged
  assign verdict = i_hash_val && i_hash_second;

  // Leading digest bytes that must be zero, capped at the digest size
  always_comb begin
    lim    = (diff_act > 32'(DIGEST_BYTS)) ? 6'(DIGEST_BYTS) : diff_act[5:0];
    fail_c = 1'b0;
    for (int k = 0; k < DIGEST_BYTS; k++) begin
      if (k < lim && i_hash_dat[255-8*k -: 8] != 8'h00)
        fail_c = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      act_busy          <= 1'b0;
      hold_val          <= 1'b0;
      o_val             <= 1'b0;
      o_difficulty_fail <= 1'b0;
    end else begin
      o_val <= verdict;
      if (verdict)
        o_difficulty_fail <= fail_c;
      if (verdict) begin
        if (hold_val) begin
          // Held difficulty moves up, a new start takes its place
          diff_act <= hold_diff;
          hold_val <= i_hdr_start;
          if (i_hdr_start)
            hold_diff <= i_difficulty;
        end else if (i_hdr_start) begin
          diff_act <= i_difficulty;
        end else begin
          act_busy <= 1'b0;
        end
      end else if (i_hdr_start) begin
        if (act_busy) begin
          hold_diff <= i_difficulty;
          hold_val  <= 1'b1;
        end else begin
          diff_act <= i_difficulty;
          act_busy <= 1'b1;
        end
      end
    end
  end

endmodule

//--- zcash_difficulty_top.sv
// ================================================
// Zcash header SHA256d difficulty check
// ================================================
`timescale 1ns/10ps

module zcash_difficulty_top #(
  parameter int DAT_BYTS   = zcash_diff_pkg::DAT_BYTS_DEF,
  parameter int HDR_BYTS   = zcash_diff_pkg::HDR_BYTS_DEF,
  parameter int FIFO_DEPTH = zcash_diff_pkg::FIFO_DEPTH_DEF
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_val,
  input  logic [DAT_BYTS*8-1:0] i_dat,
  input  logic                  i_sop,
  input  logic                  i_eop,
  input  logic [31:0]           i_difficulty,
  output logic                  o_credit,
  output logic                  o_val,
  output logic                  o_difficulty_fail
);

  // FIFO to builder
  logic                  fifo_val;
  logic [DAT_BYTS*8-1:0] fifo_dat;
  logic                  fifo_eop;
  logic                  fifo_pop;
  logic [31:0]           fifo_difficulty;
  logic                  hdr_start;
  // Builder to core
  logic                  blk_val;
  logic                  blk_rdy;
  logic [511:0]          blk_dat;
  logic                  blk_first;
  logic                  blk_last;
  // Core digest back to builder and checker
  logic                  hash_val;
  logic [255:0]          hash_dat;
  logic                  hash_second;

  hdr_credit_fifo #(
    .DAT_BYTS   ( DAT_BYTS   ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_fifo (
    .i_clk        ( i_clk           ),
    .i_rst        ( i_rst           ),
    .i_val        ( i_val           ),
    .i_dat        ( i_dat           ),
    .i_sop        ( i_sop           ),
    .i_eop        ( i_eop           ),
    .i_difficulty ( i_difficulty    ),
    .i_pop        ( fifo_pop        ),
    .o_val        ( fifo_val        ),
    .o_dat        ( fifo_dat        ),
    .o_sop        (                 ),
    .o_eop        ( fifo_eop        ),
    .o_difficulty ( fifo_difficulty ),
    .o_hdr_start  ( hdr_start       ),
    .o_credit     ( o_credit        )
  );

  sha256_block_builder #(
    .DAT_BYTS ( DAT_BYTS ),
    .HDR_BYTS ( HDR_BYTS )
  ) u_builder (
    .i_clk         ( i_clk       ),
    .i_rst         ( i_rst       ),
    .i_fifo_val    ( fifo_val    ),
    .i_fifo_dat    ( fifo_dat    ),
    .i_fifo_eop    ( fifo_eop    ),
    .i_blk_rdy     ( blk_rdy     ),
    .i_hash_val    ( hash_val    ),
    .i_hash_dat    ( hash_dat    ),
    .o_fifo_pop    ( fifo_pop    ),
    .o_blk_val     ( blk_val     ),
    .o_blk_dat     ( blk_dat     ),
    .o_blk_first   ( blk_first   ),
    .o_blk_last    ( blk_last    ),
    .o_hash_second ( hash_second )
  );

  sha256_compress u_compress (
    .i_clk       ( i_clk     ),
    .i_rst       ( i_rst     ),
    .i_blk_val   ( blk_val   ),
    .i_blk_dat   ( blk_dat   ),
    .i_blk_first ( blk_first ),
    .i_blk_last  ( blk_last  ),
    .o_blk_rdy   ( blk_rdy   ),
    .o_hash_val  ( hash_val  ),
    .o_hash_dat  ( hash_dat  )
  );

  difficulty_check u_check (
    .i_clk             ( i_clk             ),
    .i_rst             ( i_rst             ),
    .i_hdr_start       ( hdr_start         ),
    .i_difficulty      ( fifo_difficulty   ),
    .i_hash_val        ( hash_val          ),
    .i_hash_second     ( hash_second       ),
    .i_hash_dat        ( hash_dat          ),
    .o_val             ( o_val             ),
    .o_difficulty_fail ( o_difficulty_fail )
  );

endmodule

//--- tb_sha256_model.svh
// ================================================
// Reference SHA-256 model and LFSR
// ================================================
`ifndef TB_SHA256_MODEL_SVH
`define TB_SHA256_MODEL_SVH

// Round constants and initial hash, filled by init_sha_tables
logic [31:0] k_tab [64];
logic [31:0] iv_tab [8];
// Stimulus LFSR state
logic [15:0] lfsr_state = 16'd29;

function automatic logic [31:0] rotr32(input logic [31:0] x, input int n);
  return (x >> n) | (x << (32 - n));
endfunction

// First 32 fraction bits of p raised to e
function automatic logic [31:0] root_frac_bits(input int p, input real e);
  real    r;
  longint v;
  r = (e == 0.5) ? $sqrt($itor(p)) : $pow($itor(p), e);
  r = r - $floor(r);
  v = $floor(r * 4294967296.0);
  return v[31:0];
endfunction

// Constants from the cube and square roots of the first primes
function automatic void init_sha_tables();
  int n;
  int p;
  bit is_prime;
  n = 0;
  p = 2;
  while (n < 64) begin
    is_prime = 1'b1;
    for (int d = 2; d * d <= p; d++) begin
      if (p % d == 0)
        is_prime = 1'b0;
    end
    if (is_prime) begin
      k_tab[n] = root_frac_bits(p, 1.0 / 3.0);
      if (n < 8)
        iv_tab[n] = root_frac_bits(p, 0.5);
      n++;
    end
    p++;
  end
endfunction

// Plain SHA-256 over a byte string, big-endian digest
function automatic logic [255:0] sha256_bytes(input logic [7:0] msg [$]);
  logic [7:0]  pad_q [$];
  logic [31:0] w [64];
  logic [31:0] h [8];
  logic [31:0] s [8];
  logic [31:0] t1;
  logic [31:0] t2;
  logic [63:0] bit_len;
  bit_len = 64'(msg.size()) * 64'd8;
  pad_q = msg;
  pad_q.push_back(8'h80);
  while (pad_q.size() % 64 != 56)
    pad_q.push_back(8'h00);
  for (int i = 7; i >= 0; i--)
    pad_q.push_back(bit_len[8*i +: 8]);
  for (int i = 0; i < 8; i++)
    h[i] = iv_tab[i];
  for (int blk = 0; blk < pad_q.size() / 64; blk++) begin
    for (int t = 0; t < 16; t++)
      w[t] = {pad_q[64*blk + 4*t], pad_q[64*blk + 4*t + 1],
              pad_q[64*blk + 4*t + 2], pad_q[64*blk + 4*t + 3]};
    // Full 64 word schedule up front
    for (int t = 16; t < 64; t++)
      w[t] = (rotr32(w[t-2], 17) ^ rotr32(w[t-2], 19) ^ (w[t-2] >> 10)) + w[t-7]
           + (rotr32(w[t-15], 7) ^ rotr32(w[t-15], 18) ^ (w[t-15] >> 3)) + w[t-16];
    for (int i = 0; i < 8; i++)
      s[i] = h[i];
    for (int t = 0; t < 64; t++) begin
      t1 = s[7] + (rotr32(s[4], 6) ^ rotr32(s[4], 11) ^ rotr32(s[4], 25))
         + ((s[4] & s[5]) ^ (~s[4] & s[6])) + k_tab[t] + w[t];
      t2 = (rotr32(s[0], 2) ^ rotr32(s[0], 13) ^ rotr32(s[0], 22))
         + ((s[0] & s[1]) ^ (s[0] & s[2]) ^ (s[1] & s[2]));
      for (int i = 7; i > 0; i--)
        s[i] = s[i-1];
      // s[4] holds the old d here
      s[4] = s[4] + t1;
      s[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++)
      h[i] = h[i] + s[i];
  end
  return {h[0], h[1], h[2], h[3], h[4], h[5], h[6], h[7]};
endfunction

// SHA-256 of the SHA-256 digest bytes
function automatic logic [255:0] sha256d_bytes(input logic [7:0] msg [$]);
  logic [255:0] d1;
  logic [7:0]   dq [$];
  d1 = sha256_bytes(msg);
  for (int i = 0; i < 32; i++)
    dq.push_back(d1[255-8*i -: 8]);
  return sha256_bytes(dq);
endfunction

// Zero bytes at the front of the digest, byte 0 is the top byte
function automatic int lead_zero_bytes(input logic [255:0] dig);
  int n;
  n = 0;
  while (n < 32 && dig[255-8*n -: 8] == 8'h00)
    n++;
  return n;
endfunction

// Difficulty above 32 counts as 32
function automatic logic expect_fail(input logic [255:0] dig, input logic [31:0] diff);
  int need;
  need = (diff > 32) ? 32 : int'(diff);
  return lead_zero_bytes(dig) < need;
endfunction

// 16 bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return r;
endfunction

`endif

//--- tb_zcash_difficulty.sv
// ================================================
// SHA256d difficulty check testbench
// ================================================
`timescale 1ns/10ps

module tb_zcash_difficulty;

  import zcash_diff_pkg::*;

  // A 140 byte header splits evenly into 4 byte beats
  localparam int BEAT_BYTS = 4;
  localparam int HDR_BYTS  = HDR_BYTS_DEF;
  localparam int DEPTH     = FIFO_DEPTH_DEF;
  localparam int BEATS     = HDR_BYTS / BEAT_BYTS;
  // Each header goes out once without gaps and once with gaps
  localparam int N_HDR     = 6;
  localparam int NONCE_POS = 108;
  localparam longint WDOG_NS = 2 * N_HDR * 5 * 70 * 100 + 10000;

  `include "tb_sha256_model.svh"

  typedef struct packed {
    logic [3:0]             gap;
    logic                   sop;
    logic                   eop;
    logic [31:0]            diff;
    logic [BEAT_BYTS*8-1:0] dat;
  } beat_t;

  logic                   i_clk = 1'b0;
  logic                   i_rst;
  logic                   i_val;
  logic [BEAT_BYTS*8-1:0] i_dat;
  logic                   i_sop;
  logic                   i_eop;
  logic [31:0]            i_difficulty;
  logic                   o_credit;
  logic                   o_val;
  logic                   o_difficulty_fail;

  beat_t       beat_q [$];
  beat_t       cur_beat;
  logic        exp_q [$];
  logic        exp_fail;
  logic [7:0]  hdr_mem [N_HDR][HDR_BYTS];
  logic [31:0] hdr_diff [N_HDR];
  logic        hdr_exp [N_HDR];
  int          credits;
  int          err_cnt;
  int          chk_cnt;
  int          wait_left;

  zcash_difficulty_top #(
    .DAT_BYTS   ( BEAT_BYTS ),
    .HDR_BYTS   ( HDR_BYTS  ),
    .FIFO_DEPTH ( DEPTH     )
  ) u_dut (
    .i_clk             ( i_clk             ),
    .i_rst             ( i_rst             ),
    .i_val             ( i_val             ),
    .i_dat             ( i_dat             ),
    .i_sop             ( i_sop             ),
    .i_eop             ( i_eop             ),
    .i_difficulty      ( i_difficulty      ),
    .o_credit          ( o_credit          ),
    .o_val             ( o_val             ),
    .o_difficulty_fail ( o_difficulty_fail )
  );

  always #50 i_clk = ~i_clk;

  function automatic logic [255:0] header_digest(input int idx);
    logic [7:0] q [$];
    for (int i = 0; i < HDR_BYTS; i++)
      q.push_back(hdr_mem[idx][i]);
    return sha256d_bytes(q);
  endfunction

  task automatic fill_random(input int idx);
    for (int i = 0; i < HDR_BYTS; i++)
      hdr_mem[idx][i] = 8'(rand_bits(8));
  endtask

  // Count the nonce up until the digest opens with a zero byte
  task automatic find_nonce(input int idx);
    int tries;
    int pos;
    tries = 0;
    while (lead_zero_bytes(header_digest(idx)) == 0 && tries < 100000) begin
      pos = NONCE_POS;
      hdr_mem[idx][pos] = hdr_mem[idx][pos] + 8'd1;
      while (hdr_mem[idx][pos] == 8'h00 && pos < HDR_BYTS - 1) begin
        pos++;
        hdr_mem[idx][pos] = hdr_mem[idx][pos] + 8'd1;
      end
      tries++;
    end
    if (lead_zero_bytes(header_digest(idx)) == 0) begin
      err_cnt++;
      $display("No nonce found that gives a digest with a leading zero byte");
    end
  endtask

  task automatic model_self_test();
    logic [7:0]   q [$];
    logic [255:0] d;
    q.push_back(8'h61);
    q.push_back(8'h62);
    q.push_back(8'h63);
    d = sha256_bytes(q);
    if (d !== 256'hba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad) begin
      err_cnt++;
      $display("Reference SHA-256 of abc is wrong, got %h", d);
    end
  endtask

  task automatic prepare_headers();
    int nz;
    fill_random(0);
    hdr_diff[0] = 32'd0;
    // Header 1 is searched for a leading zero byte
    fill_random(1);
    find_nonce(1);
    nz = lead_zero_bytes(header_digest(1));
    hdr_diff[1] = nz;
    // Header 2 repeats header 1 with one more zero byte required
    for (int i = 0; i < HDR_BYTS; i++)
      hdr_mem[2][i] = hdr_mem[1][i];
    hdr_diff[2] = nz + 1;
    // Above the digest size
    fill_random(3);
    hdr_diff[3] = 32'd40;
    // Top bit set and low bits clear
    fill_random(4);
    hdr_diff[4] = 32'h8000_0000;
    fill_random(5);
    hdr_diff[5] = rand_bits(1);
    for (int i = 0; i < N_HDR; i++) begin
      hdr_exp[i] = expect_fail(header_digest(i), hdr_diff[i]);
      $display("Header %0d difficulty %0d digest %h expect fail %0b",
               i, hdr_diff[i], header_digest(i), hdr_exp[i]);
    end
  endtask

  task automatic queue_header(input int idx, input bit use_gaps);
    beat_t b;
    for (int n = 0; n < BEATS; n++) begin
      b.gap  = use_gaps ? 4'(rand_bits(2)) : 4'd0;
      b.sop  = (n == 0);
      b.eop  = (n == BEATS - 1);
      b.diff = hdr_diff[idx];
      // Earliest byte in the low bits
      for (int j = 0; j < BEAT_BYTS; j++)
        b.dat[8*j +: 8] = hdr_mem[idx][BEAT_BYTS*n + j];
      beat_q.push_back(b);
    end
    exp_q.push_back(hdr_exp[idx]);
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge i_clk);
      if (o_val !== 1'b0) begin
        err_cnt++;
        $display("ERR %0t o_val exp 0 got %b", $time, o_val);
      end
      if (o_credit !== 1'b0) begin
        err_cnt++;
        $display("ERR %0t o_credit exp 0 got %b", $time, o_credit);
      end
    end
  endtask

  // All beats are popped by the last verdict, so every credit is back
  task automatic wait_verdicts();
    while (exp_q.size() != 0)
      @(posedge i_clk);
    repeat (20) @(posedge i_clk);
    if (credits != DEPTH) begin
      err_cnt++;
      $display("%0t: only %0d of %0d credits returned after the last verdict",
               $time, credits, DEPTH);
    end
  endtask

  // Sender counts credits and drives beats on the falling edge
  always @(negedge i_clk) begin
    if (o_credit === 1'b1)
      credits++;
    if (credits > DEPTH) begin
      err_cnt++;
      $display("%0t: credit returned with no beat outstanding", $time);
      credits = DEPTH;
    end
    i_val = 1'b0;
    i_sop = 1'b0;
    i_eop = 1'b0;
    if (beat_q.size() != 0) begin
      if (wait_left < beat_q[0].gap) begin
        wait_left++;
      end else if (credits > 0) begin
        cur_beat     = beat_q.pop_front();
        i_val        = 1'b1;
        i_dat        = cur_beat.dat;
        i_sop        = cur_beat.sop;
        i_eop        = cur_beat.eop;
        i_difficulty = cur_beat.diff;
        credits--;
        wait_left    = 0;
      end
    end
  end

  // Scoreboard checks verdicts in header order
  always @(negedge i_clk) begin
    if (o_val === 1'b1) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("%0t: o_val pulse with no header outstanding", $time);
      end else begin
        exp_fail = exp_q.pop_front();
        chk_cnt++;
        if (o_difficulty_fail !== exp_fail) begin
          err_cnt++;
          $display("ERR %0t o_difficulty_fail exp %0b got %0b",
                   $time, exp_fail, o_difficulty_fail);
        end
      end
    end
  end

  // Watchdog
  initial begin
    #(WDOG_NS);
    $display("Timeout after %0d ns with %0d verdicts still missing", WDOG_NS, exp_q.size());
    $display("Finished with errors");
    $finish;
  end

  initial begin
    i_rst        = 1'b1;
    i_val        = 1'b0;
    i_dat        = '0;
    i_sop        = 1'b0;
    i_eop        = 1'b0;
    i_difficulty = '0;
    credits      = DEPTH;
    err_cnt      = 0;
    chk_cnt      = 0;
    wait_left    = 0;
    init_sha_tables();
    model_self_test();
    prepare_headers();
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    check_idle(10);
    // Back to back as fast as credits allow
    @(posedge i_clk);
    for (int i = 0; i < N_HDR; i++)
      queue_header(i, 1'b0);
    wait_verdicts();
    // Same headers with random gaps
    for (int i = 0; i < N_HDR; i++)
      queue_header(i, 1'b1);
    wait_verdicts();
    $display("Errors %0d, verdicts checked %0d of %0d", err_cnt, chk_cnt, 2 * N_HDR);
    if (err_cnt == 0 && chk_cnt == 2 * N_HDR)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- all.f
+incdir+.
zcash_diff_pkg.sv
hdr_credit_fifo.sv
sha256_block_builder.sv
sha256_compress.sv
difficulty_check.sv
zcash_difficulty_top.sv
tb_zcash_difficulty.sv

//--- Bender.yml
package:
  name: zcash_difficulty

sources:
  - zcash_diff_pkg.sv
  - hdr_credit_fifo.sv
  - sha256_block_builder.sv
  - sha256_compress.sv
  - difficulty_check.sv
  - zcash_difficulty_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_zcash_difficulty.sv
